/* audio_pkg.sv */
package audio_pkg;

  typedef logic [7:0]  sample_t; // Offset binary, 128 is silence
  typedef logic [31:0] addr_t;   // Wishbone byte address
  typedef logic [31:0] word_t;   // Wishbone data word

  localparam sample_t SILENCE   = 8'd128; // Mid-scale level
  localparam sample_t HALF_BIAS = 8'd64;  // Re-centres a halved sample

  // Effect select as seen on the top-level port
  typedef enum logic [1:0] {
    EFF_BYPASS = 2'd0, // Straight through
    EFF_ECHO   = 2'd1, // Average with delayed sample
    EFF_HALF   = 2'd2, // Half amplitude around mid-scale
    EFF_MUTE   = 2'd3  // Constant silence
  } effect_t;

  // One sample and the effect it was captured under
  typedef struct packed {
    sample_t sample; // Audio payload
    effect_t effect; // Effect at capture time
  } sample_beat_t;

  // Request from echo store to bus master
  typedef enum logic [1:0] {
    OP_IDLE  = 2'd0, // No request
    OP_READ  = 2'd1, // Fetch history word
    OP_WRITE = 2'd2  // Store new sample
  } bus_op_t;

endpackage

/* clk_divider.sv */
`timescale 1ns/1ps

module clk_divider #(
  parameter int CLK_COUNT = 4 // hwclk cycles per half period
) (
  input  logic hwclk,
  input  logic rst_n,
  output logic sclk,
  output logic rise_stb,
  output logic fall_stb
);

  localparam int CNT_W = (CLK_COUNT > 1) ? $clog2(CLK_COUNT) : 1;

  logic [CNT_W-1:0] cnt;  // Position in half period
  logic             wrap; // Last cycle before toggle

  assign wrap = (cnt == CNT_W'(CLK_COUNT - 1));

  always_ff @(posedge hwclk or negedge rst_n) begin
    if (!rst_n) begin
      cnt      <= '0;
      sclk     <= 1'b0; // Serial clock idles low
      rise_stb <= 1'b0;
      fall_stb <= 1'b0;
    end else begin
      rise_stb <= wrap && !sclk; // High in first cycle of sclk high
      fall_stb <= wrap && sclk;  // High in first cycle of sclk low
      if (wrap) begin
        cnt  <= '0;
        sclk <= ~sclk;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

/* adc_to_i2s.sv */
`timescale 1ns/1ps

module adc_to_i2s (
  input  logic                    hwclk,
  input  logic                    rst_n,
  input  logic                    rise_stb,
  input  logic                    fall_stb,
  input  logic                    adc_serial_in,
  input  audio_pkg::effect_t      effect_sel,
  output logic                    ws,
  output audio_pkg::sample_beat_t out_beat,
  output logic                    out_valid,
  input  logic                    out_ready
);

  logic [3:0]         period;      // Serial clock period within frame
  logic [3:0]         period_nxt;
  audio_pkg::sample_t shreg;       // Left bits gathered so far
  logic               capture;     // Data bit sampled this cycle
  logic               sample_done; // Bit 0 sampled this cycle
  logic               load;        // Room for the finished sample

  assign period_nxt  = period + 4'd1;
  assign capture     = rise_stb && (period >= 4'd1) && (period <= 4'd8); // One-bit delay
  assign sample_done = rise_stb && (period == 4'd8);
  assign load        = sample_done && (!out_valid || out_ready); // Else new sample dropped

  always_ff @(posedge hwclk or negedge rst_n) begin
    if (!rst_n) begin
      period <= 4'hF; // First falling edge opens period 0
      ws     <= 1'b1;
    end else if (fall_stb) begin
      period <= period_nxt;
      ws     <= period_nxt[3]; // Low for the left half
    end
  end

  always_ff @(posedge hwclk) begin
    if (capture) begin
      shreg <= {shreg[6:0], adc_serial_in}; // MSB first
    end
  end

  always_ff @(posedge hwclk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0; // Beat taken
    end
  end

  always_ff @(posedge hwclk) begin
    if (load) begin
      out_beat.sample <= {shreg[6:0], adc_serial_in}; // Includes bit 0
      out_beat.effect <= effect_sel;                  // Effect latched per sample
    end
  end

endmodule

/* audio_effect.sv */
`timescale 1ns/1ps

module audio_effect (
  input  logic                    hwclk,
  input  logic                    rst_n,
  input  audio_pkg::sample_beat_t in_beat,
  input  logic                    in_valid,
  output logic                    in_ready,
  output logic                    req_valid,
  input  logic                    req_ready,
  output audio_pkg::sample_t      req_sample,
  input  logic                    past_valid,
  input  audio_pkg::sample_t      past_sample,
  output audio_pkg::sample_beat_t out_beat,
  output logic                    out_valid,
  input  logic                    out_ready
);

  logic                    active;   // Beat in flight until output taken
  logic                    accept;
  audio_pkg::sample_beat_t beat_q;   // Beat under processing
  audio_pkg::sample_t      result;   // Processed sample
  logic [8:0]              echo_sum; // Carry kept for the average

  assign in_ready   = !active;
  assign accept     = in_valid && in_ready;
  assign req_sample = beat_q.sample; // History gets the raw input
  assign echo_sum   = {1'b0, beat_q.sample} + {1'b0, past_sample};

  always_comb begin
    case (beat_q.effect)
      audio_pkg::EFF_BYPASS: result = beat_q.sample;
      audio_pkg::EFF_ECHO:   result = echo_sum[8:1]; // Floor of the mean
      audio_pkg::EFF_HALF:   result = audio_pkg::HALF_BIAS + (beat_q.sample >> 1);
      audio_pkg::EFF_MUTE:   result = audio_pkg::SILENCE;
      default:               result = audio_pkg::SILENCE;
    endcase
  end

  always_ff @(posedge hwclk or negedge rst_n) begin
    if (!rst_n) begin
      active    <= 1'b0;
      req_valid <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (accept) begin
        active    <= 1'b1;
        req_valid <= 1'b1; // Every beat goes through the echo store
      end else if (req_valid && req_ready) begin
        req_valid <= 1'b0;
      end
      if (past_valid) begin
        out_valid <= 1'b1; // Both bus cycles finished
      end else if (out_valid && out_ready) begin
        out_valid <= 1'b0;
        active    <= 1'b0; // Ready for next beat
      end
    end
  end

  always_ff @(posedge hwclk) begin
    if (accept) begin
      beat_q <= in_beat;
    end
    if (past_valid) begin
      out_beat.sample <= result;
      out_beat.effect <= beat_q.effect; // Passed through
    end
  end

endmodule

/* echo_store.sv */
`timescale 1ns/1ps

module echo_store #(
  parameter int               ECHO_DEPTH = 16, // Ring length in samples
  parameter audio_pkg::addr_t ECHO_BASE  = '0  // SRAM byte base
) (
  input  logic                hwclk,
  input  logic                rst_n,
  input  logic                req_valid,
  output logic                req_ready,
  input  audio_pkg::sample_t  req_sample,
  output logic                past_valid,
  output audio_pkg::sample_t  past_sample,
  output audio_pkg::bus_op_t  op,
  output audio_pkg::addr_t    addr,
  output audio_pkg::word_t    wdata,
  output logic [3:0]          sel,
  input  logic                busy,
  input  logic                done,
  input  audio_pkg::word_t    rdata
);

  localparam int PTR_W = (ECHO_DEPTH > 1) ? $clog2(ECHO_DEPTH) : 1;

  typedef enum logic [2:0] {
    ST_IDLE, ST_READ, ST_WAIT_RD, ST_WRITE, ST_WAIT_WR
  } state_t;

  state_t             state;
  logic [PTR_W-1:0]   ptr;   // Oldest slot, overwritten next
  audio_pkg::sample_t new_q; // Sample to store

  assign req_ready = (state == ST_IDLE);
  assign addr      = ECHO_BASE + (audio_pkg::addr_t'(ptr) << 2); // One word per slot
  assign wdata     = audio_pkg::word_t'(new_q); // Byte 0 only
  assign sel       = 4'b0001;

  always_comb begin
    case (state)
      ST_READ:  op = audio_pkg::OP_READ;
      ST_WRITE: op = audio_pkg::OP_WRITE;
      default:  op = audio_pkg::OP_IDLE;
    endcase
  end

  always_ff @(posedge hwclk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ST_IDLE;
      ptr        <= '0;
      past_valid <= 1'b0;
    end else begin
      past_valid <= 1'b0; // Single-cycle pulse
      case (state)
        ST_IDLE: begin
          if (req_valid) begin
            state <= ST_READ;
          end
        end
        ST_READ: begin
          if (!busy) begin
            state <= ST_WAIT_RD; // Manager took the read
          end
        end
        ST_WAIT_RD: begin
          if (done) begin
            state <= ST_WRITE;
          end
        end
        ST_WRITE: begin
          if (!busy) begin
            state <= ST_WAIT_WR;
          end
        end
        ST_WAIT_WR: begin
          if (done) begin
            state      <= ST_IDLE;
            past_valid <= 1'b1;
            ptr        <= (ptr == PTR_W'(ECHO_DEPTH - 1)) ? '0 : ptr + 1'b1; // Wrap ring
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge hwclk) begin
    if (req_valid && req_ready) begin
      new_q <= req_sample;
    end
    if ((state == ST_WAIT_RD) && done) begin
      past_sample <= rdata[7:0]; // Sample from ECHO_DEPTH beats back
    end
  end

endmodule

/* wishbone_manager.sv */
`timescale 1ns/1ps

module wishbone_manager (
  input  logic               hwclk,
  input  logic               rst_n,
  input  audio_pkg::bus_op_t op,
  input  audio_pkg::addr_t   addr,
  input  audio_pkg::word_t   wdata,
  input  logic [3:0]         sel,
  output logic               busy,
  output logic               done,
  output audio_pkg::word_t   rdata,
  input  audio_pkg::word_t   wdati,
  input  logic               wack,
  output audio_pkg::addr_t   wadr,
  output audio_pkg::word_t   wdato,
  output logic [3:0]         wsel,
  output logic               wwe,
  output logic               wstb,
  output logic               wcyc
);

  typedef enum logic [1:0] {
    M_IDLE, M_BUS, M_DONE
  } state_t;

  state_t state;
  logic   start; // New request accepted

  assign busy  = (state != M_IDLE);
  assign done  = (state == M_DONE); // One cycle after ack
  assign start = (state == M_IDLE) && (op != audio_pkg::OP_IDLE);

  always_ff @(posedge hwclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= M_IDLE;
      wcyc  <= 1'b0;
      wstb  <= 1'b0;
      wwe   <= 1'b0;
    end else begin
      case (state)
        M_IDLE: begin
          if (start) begin
            state <= M_BUS;
            wcyc  <= 1'b1; // cyc and stb rise together
            wstb  <= 1'b1;
            wwe   <= (op == audio_pkg::OP_WRITE);
          end
        end
        M_BUS: begin
          if (wack) begin
            state <= M_DONE;
            wcyc  <= 1'b0; // Classic cycle ends
            wstb  <= 1'b0;
            wwe   <= 1'b0;
          end
        end
        default: state <= M_IDLE; // M_DONE lasts one cycle
      endcase
    end
  end

  always_ff @(posedge hwclk) begin
    if (start) begin
      wadr  <= addr; // Request held for the whole cycle
      wdato <= wdata;
      wsel  <= sel;
    end
    if ((state == M_BUS) && wack) begin
      rdata <= wdati;
    end
  end

endmodule

/* i2s_to_dac.sv */
`timescale 1ns/1ps

module i2s_to_dac (
  input  logic                    hwclk,
  input  logic                    rst_n,
  input  logic                    rise_stb,
  input  logic                    fall_stb,
  input  audio_pkg::sample_beat_t in_beat,
  input  logic                    in_valid,
  output logic                    in_ready,
  output logic                    dac_out,
  output logic                    word_select
);

  logic [3:0]         period;     // Serial clock period within frame
  logic [3:0]         period_nxt;
  logic               frame_go;   // Period 0 starts now
  logic               accept;
  logic               pend_full;  // Sample waiting for next frame
  audio_pkg::sample_t pend_q;
  audio_pkg::sample_t shreg;      // Bits still to send

  assign period_nxt = period + 4'd1;
  assign frame_go   = fall_stb && (period_nxt == 4'd0);
  assign in_ready   = !pend_full;
  assign accept     = in_valid && in_ready;

  always_ff @(posedge hwclk or negedge rst_n) begin
    if (!rst_n) begin
      period      <= 4'hF; // Matches the ADC frame
      word_select <= 1'b1;
      dac_out     <= 1'b0;
      pend_full   <= 1'b0;
    end else begin
      if (frame_go) begin
        pend_full <= 1'b0; // Pending sample moves to shreg
      end
      if (accept) begin
        pend_full <= 1'b1;
      end
      if (fall_stb) begin
        period      <= period_nxt;
        word_select <= period_nxt[3];
        // Bit 7 lands one period after ws falls
        if ((period_nxt >= 4'd1) && (period_nxt <= 4'd8)) begin
          dac_out <= shreg[7];
        end else begin
          dac_out <= 1'b0; // Right half and gap are zero
        end
      end
    end
  end

  always_ff @(posedge hwclk) begin
    if (accept) begin
      pend_q <= in_beat.sample;
    end
    if (frame_go) begin
      shreg <= pend_full ? pend_q : audio_pkg::SILENCE; // Silence without new data
    end else if (fall_stb && (period_nxt >= 4'd1) && (period_nxt <= 4'd8)) begin
      shreg <= {shreg[6:0], 1'b0};
    end
  end

endmodule

/* audio_top.sv */
`timescale 1ns/1ps

module audio_top #(
  parameter int               CLK_COUNT  = 4,  // hwclk cycles per half i2sclk
  parameter int               ECHO_DEPTH = 16, // Echo delay in samples
  parameter audio_pkg::addr_t ECHO_BASE  = '0  // History base in SRAM
) (
  input  logic               hwclk,
  input  logic               rst_n,
  input  logic               adc_serial_in,
  input  audio_pkg::effect_t effect_sel,
  input  audio_pkg::word_t   wdati,
  input  logic               wack,
  output logic               i2sclk,
  output logic               ws_adc,
  output logic               dac_out,
  output logic               word_select,
  output audio_pkg::addr_t   wadr,
  output audio_pkg::word_t   wdato,
  output logic [3:0]         wsel,
  output logic               wwe,
  output logic               wstb,
  output logic               wcyc
);

  logic                    rise_stb, fall_stb;              // i2sclk edge strobes
  audio_pkg::sample_beat_t adc_beat, eff_beat;              // Stage payloads
  logic                    adc_valid, adc_ready;            // ADC to effect
  logic                    eff_valid, eff_ready;            // Effect to DAC
  logic                    req_valid, req_ready;            // Echo request
  audio_pkg::sample_t      req_sample, past_sample;
  logic                    past_valid;
  audio_pkg::bus_op_t      bus_op;                          // Echo store to bus master
  audio_pkg::addr_t        bus_addr;
  audio_pkg::word_t        bus_wdata, bus_rdata;
  logic [3:0]              bus_sel;
  logic                    bus_busy, bus_done;

  clk_divider #(.CLK_COUNT(CLK_COUNT)) u_clk_div (
    .hwclk(hwclk), .rst_n(rst_n),
    .sclk(i2sclk), .rise_stb(rise_stb), .fall_stb(fall_stb)); // Shared by both links

  adc_to_i2s u_adc (
    .hwclk(hwclk), .rst_n(rst_n), .rise_stb(rise_stb), .fall_stb(fall_stb),
    .adc_serial_in(adc_serial_in), .effect_sel(effect_sel), .ws(ws_adc),
    .out_beat(adc_beat), .out_valid(adc_valid), .out_ready(adc_ready));

  audio_effect u_effect (
    .hwclk(hwclk), .rst_n(rst_n),
    .in_beat(adc_beat), .in_valid(adc_valid), .in_ready(adc_ready),
    .req_valid(req_valid), .req_ready(req_ready), .req_sample(req_sample),
    .past_valid(past_valid), .past_sample(past_sample),
    .out_beat(eff_beat), .out_valid(eff_valid), .out_ready(eff_ready));

  echo_store #(.ECHO_DEPTH(ECHO_DEPTH), .ECHO_BASE(ECHO_BASE)) u_echo (
    .hwclk(hwclk), .rst_n(rst_n),
    .req_valid(req_valid), .req_ready(req_ready), .req_sample(req_sample),
    .past_valid(past_valid), .past_sample(past_sample),
    .op(bus_op), .addr(bus_addr), .wdata(bus_wdata), .sel(bus_sel),
    .busy(bus_busy), .done(bus_done), .rdata(bus_rdata));

  wishbone_manager u_wb (
    .hwclk(hwclk), .rst_n(rst_n),
    .op(bus_op), .addr(bus_addr), .wdata(bus_wdata), .sel(bus_sel),
    .busy(bus_busy), .done(bus_done), .rdata(bus_rdata),
    .wdati(wdati), .wack(wack), .wadr(wadr), .wdato(wdato),
    .wsel(wsel), .wwe(wwe), .wstb(wstb), .wcyc(wcyc)); // To external SRAM

  i2s_to_dac u_dac (
    .hwclk(hwclk), .rst_n(rst_n), .rise_stb(rise_stb), .fall_stb(fall_stb),
    .in_beat(eff_beat), .in_valid(eff_valid), .in_ready(eff_ready),
    .dac_out(dac_out), .word_select(word_select));

endmodule

/* audio_props.sv */
`timescale 1ns/1ps

module audio_props (
  input logic                    hwclk,
  input logic                    rst_n,
  input logic                    adc_valid,
  input logic                    adc_ready,
  input audio_pkg::sample_beat_t adc_beat,
  input logic                    eff_valid,
  input logic                    eff_ready,
  input audio_pkg::sample_beat_t eff_beat,
  input logic                    sample_done,
  input logic                    wcyc,
  input logic                    wstb,
  input logic                    wack
);

  adc_hold: assert property (@(posedge hwclk) disable iff (!rst_n)
    adc_valid && !adc_ready |=> adc_valid && $stable(adc_beat))
    else $error("ADC beat dropped or changed before ready");

  eff_hold: assert property (@(posedge hwclk) disable iff (!rst_n)
    eff_valid && !eff_ready |=> eff_valid && $stable(eff_beat))
    else $error("Effect beat dropped or changed before ready");

  cyc_is_stb: assert property (@(posedge hwclk) disable iff (!rst_n) wcyc == wstb)
    else $error("wcyc and wstb differ");

  cyc_until_ack: assert property (@(posedge hwclk) disable iff (!rst_n)
    wcyc && !wack |=> wcyc)
    else $error("Bus cycle ended without ack");

  no_drop: assert property (@(posedge hwclk) disable iff (!rst_n)
    sample_done |-> !(adc_valid && !adc_ready))
    else $error("ADC sample lost to back-pressure");

endmodule

/* tb_audio_top.sv */
`timescale 1ns/1ps

module tb_audio_top;

  localparam int               CLK_COUNT  = 4;
  localparam int               ECHO_DEPTH = 16;
  localparam audio_pkg::addr_t ECHO_BASE  = '0;
  localparam int               EDGE_LIMIT = 400;   // Cycles allowed per serial edge
  localparam int               DRAIN_LIMIT = 40000; // Cycles allowed for a whole run

  logic               hwclk = 1'b0;
  logic               rst_n, adc_serial_in, wack;
  audio_pkg::effect_t effect_sel;
  audio_pkg::word_t   wdati, wdato;
  audio_pkg::addr_t   wadr;
  logic [3:0]         wsel;
  logic               i2sclk, ws_adc, dac_out, word_select, wwe, wstb, wcyc;

  audio_pkg::sample_beat_t stim_q[$];  // Samples waiting for an ADC frame
  logic [7:0]              exp_q[$];   // DAC value per output frame
  logic [7:0]              bus_q[$];   // Samples the SRAM should see written
  logic [7:0]              hist[ECHO_DEPTH];
  audio_pkg::word_t        mem[64];
  int hist_ptr, bus_ptr, ack_delay, rd_count, wr_count;
  int sent_count, checked_count, check_count, errors;
  bit want_write;               // Write due after the read
  int unsigned seed_val;

  audio_top #(.CLK_COUNT(CLK_COUNT), .ECHO_DEPTH(ECHO_DEPTH), .ECHO_BASE(ECHO_BASE)) dut (
    .hwclk(hwclk), .rst_n(rst_n), .adc_serial_in(adc_serial_in), .effect_sel(effect_sel),
    .wdati(wdati), .wack(wack), .i2sclk(i2sclk), .ws_adc(ws_adc), .dac_out(dac_out),
    .word_select(word_select), .wadr(wadr), .wdato(wdato), .wsel(wsel), .wwe(wwe),
    .wstb(wstb), .wcyc(wcyc));

  bind audio_top audio_props u_props (
    .hwclk(hwclk), .rst_n(rst_n),
    .adc_valid(adc_valid), .adc_ready(adc_ready), .adc_beat(adc_beat),
    .eff_valid(eff_valid), .eff_ready(eff_ready), .eff_beat(eff_beat),
    .sample_done(u_adc.sample_done), .wcyc(wcyc), .wstb(wstb), .wack(wack));

  initial begin
    forever #5 hwclk = ~hwclk; // 100 MHz
  end

  task automatic end_run();
    $display("Checks: %0d, errors: %0d", check_count, errors);
    if (errors == 0) $display("Result: PASSED");
    else $display("Result: FAILED");
    $finish;
  endtask

  task automatic compare_values(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout: %s did not happen in time", what);
    errors++;
    end_run();
  endtask

  // Word select of either link reaches a level
  task automatic wait_ws(input bit dac_side, input logic level);
    int n;
    n = 0;
    while (((dac_side ? word_select : ws_adc) !== level) && (n < EDGE_LIMIT)) begin
      @(negedge hwclk);
      n++;
    end
    if (n >= EDGE_LIMIT) stop_on_timeout("word select change");
  endtask

  task automatic wait_sclk(input bit rising);
    logic prev;
    bit   found;
    int   n;
    prev  = i2sclk;
    found = 1'b0;
    n     = 0;
    while (!found && (n < EDGE_LIMIT)) begin
      @(negedge hwclk);
      found = rising ? (!prev && i2sclk) : (prev && !i2sclk);
      prev  = i2sclk;
      n++;
    end
    if (!found) stop_on_timeout("i2sclk edge");
  endtask

  task automatic wait_checked(input int target);
    int n;
    n = 0;
    while ((checked_count < target) && (n < DRAIN_LIMIT)) begin
      @(negedge hwclk);
      n++;
    end
    if (n >= DRAIN_LIMIT) stop_on_timeout("DAC output frame");
  endtask

  // Expected DAC value and the next echo history step
  function automatic logic [7:0] predict_sample(input audio_pkg::sample_beat_t b);
    logic [8:0] sum;
    logic [7:0] y;
    sum = {1'b0, b.sample} + {1'b0, hist[hist_ptr]};
    case (b.effect)
      audio_pkg::EFF_BYPASS: y = b.sample;
      audio_pkg::EFF_ECHO:   y = sum[8:1];            // Floor of the mean
      audio_pkg::EFF_HALF:   y = 8'd64 + (b.sample >> 1);
      default:               y = 8'd128;              // Mute
    endcase
    hist[hist_ptr] = b.sample;
    hist_ptr = (hist_ptr + 1) % ECHO_DEPTH;
    return y;
  endfunction

  // One sample per frame with bypassed silence when nothing is queued
  task automatic drive_adc();
    audio_pkg::sample_beat_t b;
    forever begin
      wait_ws(1'b0, 1'b1);
      wait_ws(1'b0, 1'b0); // Period 0
      if (stim_q.size() > 0) begin
        b = stim_q.pop_front();
      end else begin
        b.sample = 8'd128;
        b.effect = audio_pkg::EFF_BYPASS;
      end
      effect_sel = b.effect;
      exp_q.push_back(predict_sample(b)); // Heard one frame later
      bus_q.push_back(b.sample);
      sent_count++;
      for (int i = 7; i >= 0; i--) begin
        wait_sclk(1'b0); // Bit 7 in period 1
        adc_serial_in = b.sample[i];
      end
    end
  endtask

  task automatic watch_dac();
    logic [7:0] got;
    forever begin
      wait_ws(1'b1, 1'b1);
      wait_ws(1'b1, 1'b0);
      wait_sclk(1'b1); // Period 0 rise carries no data
      for (int i = 7; i >= 0; i--) begin
        wait_sclk(1'b1);
        got[i] = dac_out;
      end
      if (exp_q.size() > 0) begin
        compare_values("dac_out sample", got, exp_q.pop_front());
      end else begin
        errors++;
        $display("DAC error at %0t ns: a frame came out with no sample expected", $time);
      end
      checked_count++;
    end
  endtask

  task automatic serve_access();
    int idx;
    idx = wadr[7:2];
    compare_values("wadr", wadr, ECHO_BASE + 4 * bus_ptr);
    if (!wwe) begin
      if (want_write) begin
        errors++;
        $display("Bus error at %0t ns: a second read came before the write", $time);
      end
      wdati      = mem[idx];
      want_write = 1'b1;
      rd_count++;
    end else begin
      if (!want_write || (bus_q.size() == 0)) begin
        errors++;
        $display("Bus error at %0t ns: a write came without a read before it", $time);
      end else begin
        compare_values("wsel", wsel, 4'b0001);
        compare_values("wdato byte 0", wdato[7:0], bus_q.pop_front());
      end
      for (int k = 0; k < 4; k++) begin
        if (wsel[k]) mem[idx][8*k +: 8] = wdato[8*k +: 8];
      end
      want_write = 1'b0;
      bus_ptr    = (bus_ptr + 1) % ECHO_DEPTH;
      wr_count++;
    end
  endtask

  // SRAM slave with an ack after 1 to 3 cycles
  initial begin
    forever begin
      @(negedge hwclk);
      if (wack) begin
        wack = 1'b0; // Single-cycle ack
      end else if (wcyc && wstb) begin
        if (ack_delay < 0) ack_delay = $urandom % 3;
        if (ack_delay == 0) begin
          serve_access();
          wack      = 1'b1;
          ack_delay = -1;
        end else begin
          ack_delay--;
        end
      end
    end
  end

  task automatic drain_outputs();
    int n;
    n = 0;
    while ((stim_q.size() > 0) && (n < DRAIN_LIMIT)) begin
      @(negedge hwclk);
      n++;
    end
    if (n >= DRAIN_LIMIT) stop_on_timeout("ADC stimulus drain");
    wait_checked(sent_count + 1); // Frame 0 came from reset
  endtask

  task automatic queue_samples(input int n, input audio_pkg::effect_t eff, input bit mixed);
    audio_pkg::sample_beat_t b;
    for (int i = 0; i < n; i++) begin
      b.sample = 8'($urandom);
      b.effect = mixed ? audio_pkg::effect_t'($urandom % 4) : eff;
      stim_q.push_back(b);
    end
  endtask

  task automatic test_reset();
    rst_n = 1'b0;
    repeat (4) @(negedge hwclk);
    compare_values("wcyc", wcyc, 0);
    compare_values("wstb", wstb, 0);
    compare_values("wwe", wwe, 0);
    compare_values("dac_out", dac_out, 0);
    compare_values("ws_adc", ws_adc, 1);
    compare_values("i2sclk", i2sclk, 0);
    compare_values("word_select", word_select, 1);
    repeat (4) @(negedge hwclk);
    rst_n = 1'b1;
    @(negedge hwclk);
    compare_values("wcyc", wcyc, 0);
    compare_values("wstb", wstb, 0);
    compare_values("wwe", wwe, 0);
    compare_values("dac_out", dac_out, 0);
    compare_values("ws_adc", ws_adc, 1);
    compare_values("i2sclk", i2sclk, 0);
    compare_values("word_select", word_select, 1);
  endtask

  task automatic test_bypass();
    queue_samples(20, audio_pkg::EFF_BYPASS, 1'b0);
    drain_outputs();
  endtask

  task automatic test_half_mute();
    queue_samples(10, audio_pkg::EFF_HALF, 1'b0);
    queue_samples(10, audio_pkg::EFF_MUTE, 1'b0);
    drain_outputs();
  endtask

  task automatic test_echo();
    queue_samples(40, audio_pkg::EFF_ECHO, 1'b0);
    drain_outputs();
  endtask

  task automatic test_bus_traffic();
    queue_samples(ECHO_DEPTH + 4, audio_pkg::EFF_BYPASS, 1'b1);
    drain_outputs();
    wait_ws(1'b0, 1'b1);
    wait_ws(1'b0, 1'b0);
    @(negedge hwclk); // Driver has opened this frame
    compare_values("read count", rd_count, wr_count);
    compare_values("write count", wr_count, sent_count - 1);
  endtask

  task automatic test_effect_change();
    queue_samples(24, audio_pkg::EFF_BYPASS, 1'b1); // New effect almost every sample
    queue_samples(8, audio_pkg::EFF_ECHO, 1'b0);
    drain_outputs();
  endtask

  initial begin
    rst_n         = 1'b0;
    adc_serial_in = 1'b0;
    effect_sel    = audio_pkg::EFF_BYPASS;
    wdati         = '0;
    wack          = 1'b0;
    ack_delay     = -1;
    seed_val      = $urandom(19);
    foreach (mem[i]) mem[i] = '0;
    foreach (hist[i]) hist[i] = 8'd0; // SRAM starts zeroed
    exp_q.push_back(8'd128);          // Frame 0 has no sample yet
    test_reset();
    fork
      drive_adc();
      watch_dac();
    join_none
    wait_checked(3); // First frames silent
    test_bypass();
    test_half_mute();
    test_echo();
    test_bus_traffic();
    test_effect_change();
    end_run();
  end

endmodule

/* flist.f */
audio_pkg.sv
clk_divider.sv
adc_to_i2s.sv
audio_effect.sv
echo_store.sv
wishbone_manager.sv
i2s_to_dac.sv
audio_top.sv
audio_props.sv
tb_audio_top.sv

/* Bender.yml */
package:
  name: audio_path

sources:
  - audio_pkg.sv
  - clk_divider.sv
  - adc_to_i2s.sv
  - audio_effect.sv
  - echo_store.sv
  - wishbone_manager.sv
  - i2s_to_dac.sv
  - audio_top.sv
  - target: test
    files:
      - audio_props.sv
      - tb_audio_top.sv
